//--- hw/axi_sram_pkg.sv
// AXI SRAM shared definitions
package axi_sram_pkg;

  // --------------------------------------------------------------------------
  // Bus widths and memory geometry
  // --------------------------------------------------------------------------
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;
  localparam int AXI_ID_W   = 4;

  localparam int SRAM_DEPTH = 1024;
  localparam int SRAM_IDX_W = 10;
  // Byte offset bits inside one 64-bit word
  localparam int WORD_LSB   = 3;

  // --------------------------------------------------------------------------
  // Burst and response codes
  // --------------------------------------------------------------------------
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;
  localparam logic [1:0] BURST_RSVD  = 2'b11;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // --------------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------------
  // Shared by AW and AR
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

endpackage

//--- hw/axi_burst_addr.sv
// AXI burst address stepper
`timescale 1ns/10ps

module axi_burst_addr (
  input  axi_sram_pkg::axi_ax_t                i_req,
  input  logic [axi_sram_pkg::AXI_ADDR_W-1:0] i_cur_addr,
  output logic [axi_sram_pkg::AXI_ADDR_W-1:0] o_next_addr,
  output logic                                 o_illegal
);
  import axi_sram_pkg::*;

  logic [AXI_ADDR_W-1:0] beat_bytes;
  logic [AXI_ADDR_W-1:0] incr_addr;
  logic [AXI_ADDR_W-1:0] wrap_bytes;
  logic [AXI_ADDR_W-1:0] wrap_mask;
  logic                  wrap_len_ok;

  assign beat_bytes = AXI_ADDR_W'(1) << i_req.size;
  assign incr_addr  = i_cur_addr + beat_bytes;

  // Window size is beats times beat size, aligned to itself
  assign wrap_bytes = (AXI_ADDR_W'(i_req.len) + AXI_ADDR_W'(1)) << i_req.size;
  assign wrap_mask  = wrap_bytes - AXI_ADDR_W'(1);

  always_comb begin
    case (i_req.len)
      8'd1, 8'd3, 8'd7, 8'd15: wrap_len_ok = 1'b1;
      default:                 wrap_len_ok = 1'b0;
    endcase
  end

  always_comb begin
    case (i_req.burst)
      BURST_INCR: o_next_addr = incr_addr;
      BURST_WRAP: o_next_addr = (i_cur_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:    o_next_addr = i_cur_addr;
    endcase
  end

  assign o_illegal = (i_req.burst == BURST_RSVD) ||
                     ((i_req.burst == BURST_WRAP) && !wrap_len_ok) ||
                     (i_req.size > 3'(WORD_LSB));

endmodule

//--- hw/sram_bank.sv
// Byte-enabled SRAM bank
`timescale 1ns/10ps

module sram_bank (
  input  logic                                 i_aclk,
  input  logic                                 i_we,
  input  logic [axi_sram_pkg::SRAM_IDX_W-1:0] i_widx,
  input  logic [axi_sram_pkg::AXI_DATA_W-1:0] i_wdata,
  input  logic [axi_sram_pkg::AXI_STRB_W-1:0] i_wbe,
  input  logic                                 i_re,
  input  logic [axi_sram_pkg::SRAM_IDX_W-1:0] i_ridx,
  output logic [axi_sram_pkg::AXI_DATA_W-1:0] o_rdata
);
  import axi_sram_pkg::*;

  logic [AXI_DATA_W-1:0] mem [SRAM_DEPTH];

  // Write port, one byte lane per strobe bit
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (i_wbe[b]) begin
          mem[i_widx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds while i_re is low
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_ridx];
    end
  end

endmodule

//--- hw/axi_sram_rd.sv
// AXI SRAM read engine
`timescale 1ns/10ps

module axi_sram_rd (
  input  logic                                 i_aclk,
  input  logic                                 i_arst_n,
  input  axi_sram_pkg::axi_ax_t                i_ar,
  input  logic                                 i_ar_valid,
  output logic                                 o_ar_ready,
  output axi_sram_pkg::axi_r_t                 o_r,
  output logic                                 o_r_valid,
  input  logic                                 i_r_ready,
  output logic                                 o_re,
  output logic [axi_sram_pkg::SRAM_IDX_W-1:0] o_ridx,
  input  logic [axi_sram_pkg::AXI_DATA_W-1:0] i_rdata
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_HOLD
  } rd_state_t;

  rd_state_t             state;
  axi_ax_t               req;
  logic [AXI_ADDR_W-1:0] cur_addr;
  logic [AXI_ADDR_W-1:0] next_addr;
  logic                  illegal;
  logic [7:0]            beat_cnt;
  logic                  last_beat;
  logic                  beat_err;
  logic                  ar_fire;
  logic                  r_fire;
  logic                  r_load;

  assign ar_fire    = i_ar_valid & o_ar_ready;
  assign r_fire     = o_r_valid & i_r_ready;
  assign o_ar_ready = (state == RD_IDLE);
  assign last_beat  = (beat_cnt == req.len);

  // First HOLD cycle, memory data is on i_rdata
  assign r_load = (state == RD_HOLD) & ~o_r_valid;

  // Out of range above 8 KiB, or a bad burst
  assign beat_err = illegal | (cur_addr[AXI_ADDR_W-1:SRAM_IDX_W+WORD_LSB] != '0);

  assign o_re   = (state == RD_FETCH) & ~beat_err;
  assign o_ridx = cur_addr[SRAM_IDX_W+WORD_LSB-1:WORD_LSB];

  axi_burst_addr i_axi_burst_addr (
    .i_req       (req),
    .i_cur_addr  (cur_addr),
    .o_next_addr (next_addr),
    .o_illegal   (illegal)
  );

  // --------------------------------------------------------------------------
  // FSM and beat counter
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= RD_IDLE;
      o_r_valid <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_fire) begin
            state    <= RD_FETCH;
            beat_cnt <= '0;
          end
        end
        RD_FETCH: begin
          state <= RD_HOLD;
        end
        RD_HOLD: begin
          if (r_load) begin
            o_r_valid <= 1'b1;
          end else if (r_fire) begin
            o_r_valid <= 1'b0;
            beat_cnt  <= beat_cnt + 8'd1;
            state     <= last_beat ? RD_IDLE : RD_FETCH;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Request, address and R beat registers
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      req      <= i_ar;
      cur_addr <= i_ar.addr;
    end else if (r_fire) begin
      cur_addr <= next_addr;
    end

    if (r_load) begin
      o_r.id   <= req.id;
      o_r.data <= beat_err ? '0 : i_rdata;
      o_r.resp <= beat_err ? RESP_SLVERR : RESP_OKAY;
      o_r.last <= last_beat;
    end
  end

endmodule

//--- hw/axi_sram_wr.sv
// AXI SRAM write engine
`timescale 1ns/10ps

module axi_sram_wr (
  input  logic                                 i_aclk,
  input  logic                                 i_arst_n,
  input  axi_sram_pkg::axi_ax_t                i_aw,
  input  logic                                 i_aw_valid,
  output logic                                 o_aw_ready,
  input  axi_sram_pkg::axi_w_t                 i_w,
  input  logic                                 i_w_valid,
  output logic                                 o_w_ready,
  output axi_sram_pkg::axi_b_t                 o_b,
  output logic                                 o_b_valid,
  input  logic                                 i_b_ready,
  output logic                                 o_we,
  output logic [axi_sram_pkg::SRAM_IDX_W-1:0] o_widx,
  output logic [axi_sram_pkg::AXI_DATA_W-1:0] o_wdata,
  output logic [axi_sram_pkg::AXI_STRB_W-1:0] o_wbe
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  wr_state_t             state;
  axi_ax_t               req;
  logic [AXI_ADDR_W-1:0] cur_addr;
  logic [AXI_ADDR_W-1:0] next_addr;
  logic                  illegal;
  logic                  beat_err;
  logic                  err_flag;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;

  assign aw_fire = i_aw_valid & o_aw_ready;
  assign w_fire  = i_w_valid & o_w_ready;
  assign b_fire  = o_b_valid & i_b_ready;

  assign o_aw_ready = (state == WR_IDLE);
  assign o_w_ready  = (state == WR_DATA);
  assign o_b_valid  = (state == WR_RESP);

  assign beat_err = illegal | (cur_addr[AXI_ADDR_W-1:SRAM_IDX_W+WORD_LSB] != '0);

  // Memory write on the W transfer edge itself
  assign o_we    = w_fire & ~beat_err;
  assign o_widx  = cur_addr[SRAM_IDX_W+WORD_LSB-1:WORD_LSB];
  assign o_wdata = i_w.data;
  assign o_wbe   = i_w.strb;

  assign o_b.id   = req.id;
  assign o_b.resp = err_flag ? RESP_SLVERR : RESP_OKAY;

  axi_burst_addr i_axi_burst_addr (
    .i_req       (req),
    .i_cur_addr  (cur_addr),
    .o_next_addr (next_addr),
    .o_illegal   (illegal)
  );

  // --------------------------------------------------------------------------
  // FSM and sticky error
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= WR_IDLE;
      err_flag <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            state    <= WR_DATA;
            err_flag <= 1'b0;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            if (beat_err) begin
              err_flag <= 1'b1;
            end
            if (i_w.last) begin
              state <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state <= WR_IDLE;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // Captured request and running beat address
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      req      <= i_aw;
      cur_addr <= i_aw.addr;
    end else if (w_fire) begin
      cur_addr <= next_addr;
    end
  end

endmodule

//--- hw/axi_sram_top.sv
// AXI4 SRAM slave top level
`timescale 1ns/10ps

module axi_sram_top (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,
  // Write address
  input  axi_sram_pkg::axi_ax_t i_aw,
  input  logic                  i_aw_valid,
  output logic                  o_aw_ready,
  // Write data
  input  axi_sram_pkg::axi_w_t  i_w,
  input  logic                  i_w_valid,
  output logic                  o_w_ready,
  // Write response
  output axi_sram_pkg::axi_b_t  o_b,
  output logic                  o_b_valid,
  input  logic                  i_b_ready,
  // Read address
  input  axi_sram_pkg::axi_ax_t i_ar,
  input  logic                  i_ar_valid,
  output logic                  o_ar_ready,
  // Read data
  output axi_sram_pkg::axi_r_t  o_r,
  output logic                  o_r_valid,
  input  logic                  i_r_ready
);
  import axi_sram_pkg::*;

  logic                  mem_we;
  logic [SRAM_IDX_W-1:0] mem_widx;
  logic [AXI_DATA_W-1:0] mem_wdata;
  logic [AXI_STRB_W-1:0] mem_wbe;
  logic                  mem_re;
  logic [SRAM_IDX_W-1:0] mem_ridx;
  logic [AXI_DATA_W-1:0] mem_rdata;

  axi_sram_wr i_axi_sram_wr (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .i_aw       (i_aw),
    .i_aw_valid (i_aw_valid),
    .o_aw_ready (o_aw_ready),
    .i_w        (i_w),
    .i_w_valid  (i_w_valid),
    .o_w_ready  (o_w_ready),
    .o_b        (o_b),
    .o_b_valid  (o_b_valid),
    .i_b_ready  (i_b_ready),
    .o_we       (mem_we),
    .o_widx     (mem_widx),
    .o_wdata    (mem_wdata),
    .o_wbe      (mem_wbe)
  );

  axi_sram_rd i_axi_sram_rd (
    .i_aclk     (i_aclk),
    .i_arst_n   (i_arst_n),
    .i_ar       (i_ar),
    .i_ar_valid (i_ar_valid),
    .o_ar_ready (o_ar_ready),
    .o_r        (o_r),
    .o_r_valid  (o_r_valid),
    .i_r_ready  (i_r_ready),
    .o_re       (mem_re),
    .o_ridx     (mem_ridx),
    .i_rdata    (mem_rdata)
  );

  sram_bank i_sram_bank (
    .i_aclk  (i_aclk),
    .i_we    (mem_we),
    .i_widx  (mem_widx),
    .i_wdata (mem_wdata),
    .i_wbe   (mem_wbe),
    .i_re    (mem_re),
    .i_ridx  (mem_ridx),
    .o_rdata (mem_rdata)
  );

endmodule

//--- sim/axi_sram_assert.sv
// AXI SRAM handshake assertions
`timescale 1ns/10ps

module axi_sram_assert (
  input logic                 i_aclk,
  input logic                 i_arst_n,
  input logic                 i_ar_valid,
  input logic                 i_ar_ready,
  input axi_sram_pkg::axi_r_t i_r,
  input logic                 i_r_valid,
  input logic                 i_r_ready,
  input logic                 i_b_valid,
  input logic                 i_b_ready
);

  logic rd_busy;

  // Open from the AR transfer to the last R transfer
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_busy <= 1'b0;
    end else if (i_ar_valid && i_ar_ready) begin
      rd_busy <= 1'b1;
    end else if (i_r_valid && i_r_ready && i_r.last) begin
      rd_busy <= 1'b0;
    end
  end

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r))
    else $error("R beat dropped or changed before rready");

  b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_b_valid && !i_b_ready |=> i_b_valid)
    else $error("B valid dropped before bready");

  ar_busy: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    rd_busy |-> !i_ar_ready)
    else $error("AR ready high during a read burst");

  reset_quiet: assert property (@(posedge i_aclk)
    !i_arst_n |-> !i_r_valid && !i_b_valid)
    else $error("valid output high during reset");

endmodule

bind axi_sram_top axi_sram_assert i_axi_sram_assert (
  .i_aclk     (i_aclk),
  .i_arst_n   (i_arst_n),
  .i_ar_valid (i_ar_valid),
  .i_ar_ready (o_ar_ready),
  .i_r        (o_r),
  .i_r_valid  (o_r_valid),
  .i_r_ready  (i_r_ready),
  .i_b_valid  (o_b_valid),
  .i_b_ready  (i_b_ready)
);

//--- sim/axi_sram_tb.sv
// AXI SRAM testbench
`timescale 1ns/10ps

module axi_sram_tb;
  import axi_sram_pkg::*;

  localparam int TIMEOUT = 1000;

  // Expected R beat from the reference model
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } beat_exp_t;

  logic    aclk = 1'b0;
  logic    arst_n;
  axi_ax_t aw;
  axi_ax_t ar;
  axi_w_t  w;
  axi_b_t  b;
  axi_r_t  r;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic    ar_valid, ar_ready, r_valid, r_ready;
  logic    bp_en;

  logic [7:0]            shadow [8192];
  logic [AXI_DATA_W-1:0] wdata_buf [256];
  logic [AXI_STRB_W-1:0] wstrb_buf [256];
  beat_exp_t             exp_r_q [$];
  axi_b_t                exp_b_q [$];
  int                    n_checks = 0;
  int                    n_errors = 0;
  int                    test_errs = 0;

  always #20 aclk = ~aclk;

  axi_sram_top i_axi_sram_top (
    .i_aclk     (aclk),
    .i_arst_n   (arst_n),
    .i_aw       (aw),
    .i_aw_valid (aw_valid),
    .o_aw_ready (aw_ready),
    .i_w        (w),
    .i_w_valid  (w_valid),
    .o_w_ready  (w_ready),
    .o_b        (b),
    .o_b_valid  (b_valid),
    .i_b_ready  (b_ready),
    .i_ar       (ar),
    .i_ar_valid (ar_valid),
    .o_ar_ready (ar_ready),
    .o_r        (r),
    .o_r_valid  (r_valid),
    .i_r_ready  (r_ready)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] beat_addr(axi_ax_t ax, int n);
    logic [31:0] nbytes;
    logic [31:0] win;
    logic [31:0] base;
    logic [31:0] a;
    nbytes = 32'd1 << ax.size;
    win    = (32'(ax.len) + 32'd1) * nbytes;
    base   = ax.addr - (ax.addr % win);
    case (ax.burst)
      BURST_INCR: a = ax.addr + 32'(n) * nbytes;
      BURST_WRAP: a = base + (ax.addr - base + 32'(n) * nbytes) % win;
      default:    a = ax.addr;
    endcase
    return a;
  endfunction

  function automatic logic beat_error(axi_ax_t ax, logic [31:0] a);
    logic bad_wrap;
    bad_wrap = (ax.burst == BURST_WRAP) && !(ax.len inside {8'd1, 8'd3, 8'd7, 8'd15});
    return (ax.burst == BURST_RSVD) || bad_wrap || (ax.size > 3'd3) || (a >= 32'h2000);
  endfunction

  function automatic beat_exp_t ref_beat(axi_ax_t ax, int n);
    beat_exp_t e;
    e.id   = ax.id;
    e.addr = beat_addr(ax, n);
    e.resp = beat_error(ax, e.addr) ? RESP_SLVERR : RESP_OKAY;
    e.last = (n == int'(ax.len));
    e.data = '0;
    for (int i = 0; i < 8; i++) begin
      if (e.resp == RESP_OKAY) begin
        e.data[i*8 +: 8] = shadow[{e.addr[12:3], 3'(i)}];
      end
    end
    return e;
  endfunction

  // Shadow update for one write burst, queues the expected B
  task automatic model_write(input axi_ax_t ax);
    logic [31:0] a;
    axi_b_t      eb;
    eb.id   = ax.id;
    eb.resp = RESP_OKAY;
    for (int n = 0; n <= int'(ax.len); n++) begin
      a = beat_addr(ax, n);
      if (beat_error(ax, a)) begin
        eb.resp = RESP_SLVERR;
      end else begin
        for (int i = 0; i < 8; i++) begin
          if (wstrb_buf[n][i]) begin
            shadow[{a[12:3], 3'(i)}] = wdata_buf[n][i*8 +: 8];
          end
        end
      end
    end
    exp_b_q.push_back(eb);
  endtask

  // --------------------------------------------------------------------------
  // Master side
  // --------------------------------------------------------------------------
  task automatic wait_ready(input int ch, input string what);
    int   cnt;
    logic rdy;
    cnt = 0;
    rdy = 1'b0;
    while (!rdy && cnt < TIMEOUT) begin
      @(negedge aclk);
      rdy = (ch == 0) ? aw_ready : (ch == 1) ? w_ready : ar_ready;
      cnt++;
    end
    if (!rdy) begin
      $display("ERROR at %0t: no %s handshake within %0d cycles", $time, what, TIMEOUT);
      n_errors++;
    end
    @(posedge aclk);
    #2;
  endtask

  // Hold ready until the checker has seen every expected response
  task automatic drain(input int ch, input string what);
    int cnt;
    cnt = 0;
    while (((ch == 0) ? exp_b_q.size() : exp_r_q.size()) != 0 && cnt < TIMEOUT) begin
      if (ch == 0) begin
        b_ready = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
      end else begin
        r_ready = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
      end
      @(posedge aclk);
      #2;
      cnt++;
    end
    b_ready = 1'b0;
    r_ready = 1'b0;
    if (cnt >= TIMEOUT) begin
      $display("ERROR at %0t: %s responses missing after %0d cycles", $time, what, TIMEOUT);
      n_errors++;
      exp_b_q.delete();
      exp_r_q.delete();
    end
  endtask

  task automatic write_burst(input axi_ax_t ax);
    model_write(ax);
    aw       = ax;
    aw_valid = 1'b1;
    wait_ready(0, "AW");
    aw_valid = 1'b0;
    for (int n = 0; n <= int'(ax.len); n++) begin
      if (bp_en && $urandom_range(0, 3) == 0) begin
        @(posedge aclk);
        #2;
      end
      w.data  = wdata_buf[n];
      w.strb  = wstrb_buf[n];
      w.last  = (n == int'(ax.len));
      w_valid = 1'b1;
      wait_ready(1, "W");
      w_valid = 1'b0;
    end
    drain(0, "B");
  endtask

  task automatic read_burst(input axi_ax_t ax);
    for (int n = 0; n <= int'(ax.len); n++) begin
      exp_r_q.push_back(ref_beat(ax, n));
    end
    ar       = ax;
    ar_valid = 1'b1;
    wait_ready(2, "AR");
    ar_valid = 1'b0;
    drain(1, "R");
  endtask

  function automatic axi_ax_t mk_ax(int id, logic [31:0] addr, int len, int size,
                                    logic [1:0] burst);
    axi_ax_t ax;
    ax.id    = 4'(id);
    ax.addr  = addr;
    ax.len   = 8'(len);
    ax.size  = 3'(size);
    ax.burst = burst;
    return ax;
  endfunction

  task automatic fill_random(input int beats, input logic full);
    for (int n = 0; n < beats; n++) begin
      wdata_buf[n] = {$urandom, $urandom};
      wstrb_buf[n] = full ? 8'hff : 8'($urandom);
    end
  endtask

  task automatic report_value(input string sig, input logic [63:0] expv,
                              input logic [63:0] got);
    $display("FAIL %0t %s expected %h got %h", $time, sig, expv, got);
    n_errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %-12s errors %0d", name, n_errors - test_errs);
    test_errs = n_errors;
  endtask

  // --------------------------------------------------------------------------
  // Checker, responses are stable at the falling edge
  // --------------------------------------------------------------------------
  always @(negedge aclk) begin
    beat_exp_t e;
    axi_b_t    eb;
    if (arst_n && r_valid && r_ready) begin
      if (exp_r_q.size() == 0) begin
        $display("ERROR at %0t: R beat arrived with none expected", $time);
        n_errors++;
      end else begin
        e = exp_r_q.pop_front();
        n_checks++;
        if (r.data !== e.data) report_value($sformatf("r.data@%h", e.addr), e.data, r.data);
        if (r.resp !== e.resp) report_value("r.resp", 64'(e.resp), 64'(r.resp));
        if (r.id !== e.id) report_value("r.id", 64'(e.id), 64'(r.id));
        if (r.last !== e.last) report_value("r.last", 64'(e.last), 64'(r.last));
      end
    end
    if (arst_n && b_valid && b_ready) begin
      if (exp_b_q.size() == 0) begin
        $display("ERROR at %0t: B response arrived with none expected", $time);
        n_errors++;
      end else begin
        eb = exp_b_q.pop_front();
        n_checks++;
        if (b.resp !== eb.resp) report_value("b.resp", 64'(eb.resp), 64'(b.resp));
        if (b.id !== eb.id) report_value("b.id", 64'(eb.id), 64'(b.id));
      end
    end
  end

  initial begin
    int          len;
    int          sz;
    logic [31:0] a;
    void'($urandom(32'hc28d_752b));
    arst_n   = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    bp_en    = 1'b0;
    repeat (8) @(posedge aclk);
    #2;
    arst_n = 1'b1;

    // Known contents everywhere, pattern follows the word index
    for (int blk = 0; blk < 4; blk++) begin
      for (int n = 0; n < 256; n++) begin
        wdata_buf[n] = {32'(blk*256 + n) ^ 32'h1357_9bdf, ~32'(blk*256 + n)};
        wstrb_buf[n] = 8'hff;
      end
      write_burst(mk_ax(blk, 32'(blk*2048), 255, 3, BURST_INCR));
    end
    end_test("fill");

    fill_random(1, 1'b1);
    write_burst(mk_ax(5, 32'h0000_0128, 0, 3, BURST_INCR));
    read_burst(mk_ax(9, 32'h0000_0128, 0, 3, BURST_INCR));
    end_test("single_beat");

    for (int k = 0; k < 4; k++) begin
      len = $urandom_range(1, 40);
      sz  = $urandom_range(0, 3);
      a   = 32'($urandom_range(0, 6000));
      fill_random(len + 1, 1'b0);
      write_burst(mk_ax(k, a, len, sz, BURST_INCR));
      read_burst(mk_ax(k + 8, a, len, sz, BURST_INCR));
    end
    end_test("incr_burst");

    // Window base on 128 bytes, start beat past the first
    for (int k = 0; k < 3; k++) begin
      len = (4 << k) - 1;
      sz  = 3;
      a   = 32'($urandom_range(0, 60) * 128 + $urandom_range(1, len) * (1 << sz));
      read_burst(mk_ax(k, a, len, sz, BURST_WRAP));
    end
    end_test("wrap_read");

    len = $urandom_range(3, 7);
    fill_random(len + 1, 1'b0);
    write_burst(mk_ax(3, 32'h0000_0a40, len, 3, BURST_FIXED));
    read_burst(mk_ax(4, 32'h0000_0a40, 0, 3, BURST_INCR));
    end_test("fixed_burst");

    fill_random(4, 1'b1);
    write_burst(mk_ax(1, 32'h0000_2000, 3, 3, BURST_INCR));
    write_burst(mk_ax(2, 32'h0000_0300, 3, 3, BURST_RSVD));
    write_burst(mk_ax(3, 32'h0000_0400, 2, 3, BURST_WRAP));
    read_burst(mk_ax(4, 32'h0000_2000, 3, 3, BURST_INCR));
    read_burst(mk_ax(5, 32'h0000_0300, 3, 3, BURST_RSVD));
    read_burst(mk_ax(6, 32'h0000_0400, 2, 3, BURST_WRAP));
    read_burst(mk_ax(7, 32'h0000_0300, 3, 3, BURST_INCR));
    read_burst(mk_ax(8, 32'h0000_0400, 2, 3, BURST_INCR));
    // Words that the out of range write would alias onto
    read_burst(mk_ax(9, 32'h0000_0000, 3, 3, BURST_INCR));
    end_test("error_resp");

    bp_en = 1'b1;
    for (int k = 0; k < 4; k++) begin
      len = $urandom_range(0, 31);
      a   = 32'($urandom_range(0, 900) * 8);
      fill_random(len + 1, 1'b0);
      write_burst(mk_ax(k, a, len, 3, BURST_INCR));
      read_burst(mk_ax(15 - k, a, len, 3, BURST_INCR));
    end
    end_test("backpressure");

    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- axi_sram.f
hw/axi_sram_pkg.sv
hw/axi_burst_addr.sv
hw/sram_bank.sv
hw/axi_sram_rd.sv
hw/axi_sram_wr.sv
hw/axi_sram_top.sv
sim/axi_sram_assert.sv
sim/axi_sram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI SRAM simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module axi_sram_tb -f axi_sram.f -o axi_sram_sim || exit 1
./obj_dir/axi_sram_sim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "simulation exited with an error" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
